// ==== common/pu_spi_pkg.sv ====
`default_nettype none

package pu_spi_pkg;

  // system bus word and attribute sizes.
  localparam int pu_data_width_default = 32;
  localparam int pu_attr_width         = 4;

  localparam int pu_buf_size_default   = 6;  // words per buffer.

  // attribute bits on attr_out that are valid while signal_oe is high.
  localparam int attr_invalid  = 0;  // read while the receive buffer was empty.
  localparam int attr_overflow = 1;  // a received word was dropped since the last clear.

endpackage

`default_nettype wire

// ==== common/spi_proto_pkg.sv ====
`default_nettype none

package spi_proto_pkg;

  localparam int spi_byte_width_default = 8;  // one spi frame.

  // shifted out on miso while no send word is queued.
  localparam logic [spi_byte_width_default-1:0] spi_idle_byte = '0;

  // driver transfer state that tracks cs.
  typedef enum logic [1:0] {
    idle,    // cs high and waiting for a transfer.
    active,  // cs low while bits are moving.
    done     // cs went high and the driver winds down for one cycle.
  } spi_drv_state_t;

endpackage

`default_nettype wire

// ==== spi/spi_slave_driver.sv ====
`default_nettype none

module spi_slave_driver #(
  parameter int SPI_DATA_WIDTH = spi_proto_pkg::spi_byte_width_default
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      clear,
  input  logic [SPI_DATA_WIDTH-1:0] tx_byte,
  output logic [SPI_DATA_WIDTH-1:0] rx_byte,
  output logic                      byte_done,
  output logic                      xfer_start,
  output logic                      xfer_stop,
  input  logic                      mosi,
  input  logic                      sclk,
  input  logic                      cs,
  output logic                      miso
);

  import spi_proto_pkg::*;

  localparam int CNT_W = (SPI_DATA_WIDTH > 1) ? $clog2(SPI_DATA_WIDTH) : 1;
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SPI_DATA_WIDTH - 1);

  // [0] and [1] form the synchronizer, [2] holds the previous value.
  logic [2:0]                sclk_sync;
  logic [2:0]                cs_sync;
  logic [1:0]                mosi_sync;
  logic                      sclk_rise;
  logic                      sclk_fall;
  logic                      cs_fall;
  logic                      cs_rise;
  spi_drv_state_t            state;
  logic [CNT_W-1:0]          bit_cnt;
  logic [SPI_DATA_WIDTH-1:0] rx_shift;
  logic [SPI_DATA_WIDTH-1:0] tx_shift;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_sync <= '0;
      cs_sync   <= '1;  // bus idles deselected.
      mosi_sync <= '0;
    end else begin
      sclk_sync <= {sclk_sync[1:0], sclk};
      cs_sync   <= {cs_sync[1:0], cs};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign cs_fall   = ~cs_sync[1] & cs_sync[2];
  assign cs_rise   = cs_sync[1] & ~cs_sync[2];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= idle;
      xfer_start <= 1'b0;
      xfer_stop  <= 1'b0;
    end else begin
      xfer_start <= 1'b0;
      xfer_stop  <= 1'b0;
      case (state)
        idle: begin
          if (cs_fall) begin
            state      <= active;
            xfer_start <= 1'b1;
          end
        end
        active: begin
          if (cs_rise) begin
            state     <= done;
            xfer_stop <= 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt   <= '0;
      byte_done <= 1'b0;
      tx_shift  <= SPI_DATA_WIDTH'(spi_idle_byte);
    end else begin
      byte_done <= 1'b0;
      if (clear) begin
        bit_cnt  <= '0;
        tx_shift <= SPI_DATA_WIDTH'(spi_idle_byte);
      end else if (state == active) begin
        if (sclk_rise) begin
          bit_cnt   <= (bit_cnt == LAST_BIT) ? '0 : bit_cnt + 1'b1;
          byte_done <= (bit_cnt == LAST_BIT);
        end else if (sclk_fall) begin
          // the fall that closes a byte brings up the next one.
          tx_shift <= (bit_cnt == '0) ? tx_byte : tx_shift << 1;
        end
      end else begin
        bit_cnt <= '0;
        if (state == idle && cs_fall) begin
          tx_shift <= tx_byte;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == active && sclk_rise) begin
      rx_shift <= {rx_shift[SPI_DATA_WIDTH-2:0], mosi_sync[1]};
    end
  end

  assign rx_byte = rx_shift;  // complete while byte_done is high.
  assign miso    = tx_shift[SPI_DATA_WIDTH-1];

endmodule

`default_nettype wire

// ==== spi/spi_buffer.sv ====
`default_nettype none

module spi_buffer #(
  parameter int DATA_WIDTH = pu_spi_pkg::pu_data_width_default,
  parameter int BUF_SIZE   = pu_spi_pkg::pu_buf_size_default
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clear,
  input  logic                  push,
  input  logic [DATA_WIDTH-1:0] push_data,
  input  logic                  pop,
  output logic [DATA_WIDTH-1:0] head,
  output logic                  empty,
  output logic                  full,
  output logic                  dropped
);

  localparam int PTR_W = (BUF_SIZE > 1) ? $clog2(BUF_SIZE) : 1;
  localparam int CNT_W = $clog2(BUF_SIZE + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(BUF_SIZE - 1);
  localparam logic [CNT_W-1:0] MAX_CNT  = CNT_W'(BUF_SIZE);

  logic [DATA_WIDTH-1:0] mem [BUF_SIZE];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  do_push;
  logic                  do_pop;

  assign empty   = (count == '0);
  assign full    = (count == MAX_CNT);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];  // stale while empty.

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      dropped <= 1'b0;
    end else if (clear) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      dropped <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (push && full) begin
        dropped <= 1'b1;  // sticky until clear.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

// ==== spi/spi_transfer_framer.sv ====
`default_nettype none

module spi_transfer_framer #(
  parameter int DATA_WIDTH     = pu_spi_pkg::pu_data_width_default,
  parameter int SPI_DATA_WIDTH = spi_proto_pkg::spi_byte_width_default
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      clear,
  input  logic                      byte_done,
  input  logic                      xfer_stop,
  input  logic [SPI_DATA_WIDTH-1:0] rx_byte,
  output logic [SPI_DATA_WIDTH-1:0] tx_byte,
  input  logic [DATA_WIDTH-1:0]     send_head,
  input  logic                      send_empty,
  output logic                      send_pop,
  output logic                      recv_push,
  output logic [DATA_WIDTH-1:0]     recv_word
);

  import spi_proto_pkg::*;

  localparam int NUM_BYTES = DATA_WIDTH / SPI_DATA_WIDTH;
  localparam int IDX_W     = (NUM_BYTES > 1) ? $clog2(NUM_BYTES) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_BYTES - 1);

  logic [IDX_W-1:0]      tx_idx;
  logic [IDX_W-1:0]      rx_idx;
  logic                  tx_last;
  logic                  rx_last;
  logic [DATA_WIDTH-1:0] rx_word;

  assign tx_last = (tx_idx == LAST_IDX);
  assign rx_last = (rx_idx == LAST_IDX);

  // byte 0 is the most significant one.
  always_comb begin
    if (send_empty) begin
      tx_byte = SPI_DATA_WIDTH'(spi_idle_byte);
    end else begin
      tx_byte = send_head[DATA_WIDTH-1-int'(tx_idx)*SPI_DATA_WIDTH -: SPI_DATA_WIDTH];
    end
  end

  // the head word leaves once its last byte is on its way.
  assign send_pop = byte_done && !send_empty && tx_last;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_idx    <= '0;
      rx_idx    <= '0;
      recv_push <= 1'b0;
    end else begin
      recv_push <= 1'b0;
      if (clear || xfer_stop) begin
        tx_idx <= '0;  // a partial receive word is dropped here.
        rx_idx <= '0;
      end else if (byte_done) begin
        if (!send_empty) begin
          tx_idx <= tx_last ? '0 : tx_idx + 1'b1;
        end
        rx_idx    <= rx_last ? '0 : rx_idx + 1'b1;
        recv_push <= rx_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_done) begin
      rx_word[DATA_WIDTH-1-int'(rx_idx)*SPI_DATA_WIDTH -: SPI_DATA_WIDTH] <= rx_byte;
    end
  end

  assign recv_word = rx_word;

endmodule

`default_nettype wire

// ==== src/pu_slave_spi.sv ====
`default_nettype none

module pu_slave_spi #(
  parameter int DATA_WIDTH     = pu_spi_pkg::pu_data_width_default,
  parameter int SPI_DATA_WIDTH = spi_proto_pkg::spi_byte_width_default,
  parameter int BUF_SIZE       = pu_spi_pkg::pu_buf_size_default
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               signal_cycle,
  input  logic                               signal_wr,
  input  logic [DATA_WIDTH-1:0]              data_in,
  input  logic                               signal_oe,
  output logic [DATA_WIDTH-1:0]              data_out,
  output logic [pu_spi_pkg::pu_attr_width-1:0] attr_out,
  output logic                               flag_start,
  output logic                               flag_stop,
  input  logic                               mosi,
  output logic                               miso,
  input  logic                               sclk,
  input  logic                               cs
);

  import pu_spi_pkg::*;

  logic                      buffer_clear;
  logic [SPI_DATA_WIDTH-1:0] tx_byte;
  logic [SPI_DATA_WIDTH-1:0] rx_byte;
  logic                      byte_done;
  logic                      xfer_stop;
  logic [DATA_WIDTH-1:0]     send_head;
  logic                      send_empty;
  logic                      send_pop;
  logic                      recv_push;
  logic [DATA_WIDTH-1:0]     recv_word;
  logic [DATA_WIDTH-1:0]     recv_head;
  logic                      recv_empty;
  logic                      recv_dropped;

  // a new computation cycle empties both buffers one clock later.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      buffer_clear <= 1'b0;
    end else begin
      buffer_clear <= signal_cycle;
    end
  end

  // flag_start marks idle to active, flag_stop active to done.
  spi_slave_driver #(
    .SPI_DATA_WIDTH(SPI_DATA_WIDTH)
  ) u_spi_slave_driver (
    .clk       (clk),
    .rst       (rst),
    .clear     (buffer_clear),
    .tx_byte   (tx_byte),
    .rx_byte   (rx_byte),
    .byte_done (byte_done),
    .xfer_start(flag_start),
    .xfer_stop (xfer_stop),
    .mosi      (mosi),
    .sclk      (sclk),
    .cs        (cs),
    .miso      (miso)
  );

  assign flag_stop = xfer_stop;

  spi_transfer_framer #(
    .DATA_WIDTH    (DATA_WIDTH),
    .SPI_DATA_WIDTH(SPI_DATA_WIDTH)
  ) u_spi_transfer_framer (
    .clk       (clk),
    .rst       (rst),
    .clear     (buffer_clear),
    .byte_done (byte_done),
    .xfer_stop (xfer_stop),
    .rx_byte   (rx_byte),
    .tx_byte   (tx_byte),
    .send_head (send_head),
    .send_empty(send_empty),
    .send_pop  (send_pop),
    .recv_push (recv_push),
    .recv_word (recv_word)
  );

  spi_buffer #(
    .DATA_WIDTH(DATA_WIDTH),
    .BUF_SIZE  (BUF_SIZE)
  ) send_buffer (
    .clk      (clk),
    .rst      (rst),
    .clear    (buffer_clear),
    .push     (signal_wr),  // a write into a full buffer is lost.
    .push_data(data_in),
    .pop      (send_pop),
    .head     (send_head),
    .empty    (send_empty),
    .full     (),
    .dropped  ()
  );

  spi_buffer #(
    .DATA_WIDTH(DATA_WIDTH),
    .BUF_SIZE  (BUF_SIZE)
  ) receive_buffer (
    .clk      (clk),
    .rst      (rst),
    .clear    (buffer_clear),
    .push     (recv_push),
    .push_data(recv_word),
    .pop      (signal_oe),
    .head     (recv_head),
    .empty    (recv_empty),
    .full     (),
    .dropped  (recv_dropped)
  );

  // zero while not selected, so several units can share the bus.
  always_comb begin
    data_out = '0;
    attr_out = '0;
    if (signal_oe) begin
      if (!recv_empty) begin
        data_out = recv_head;
      end
      attr_out[attr_invalid]  = recv_empty;
      attr_out[attr_overflow] = recv_dropped;
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_pu_slave_spi.sv ====
`default_nettype none

module tb_pu_slave_spi;

  timeunit 1ns;
  timeprecision 100ps;

  import pu_spi_pkg::*;
  import spi_proto_pkg::*;

  localparam int DW       = pu_data_width_default;
  localparam int BW       = spi_byte_width_default;
  localparam int BPW      = DW / BW;  // bytes per word.
  localparam int NBUF     = pu_buf_size_default;
  localparam int HALF_CLK = 4;  // clk cycles per sclk half period.

  logic                     clk;
  logic                     rst;
  logic                     signal_cycle;
  logic                     signal_wr;
  logic [DW-1:0]            data_in;
  logic                     signal_oe;
  logic [DW-1:0]            data_out;
  logic [pu_attr_width-1:0] attr_out;
  logic                     flag_start;
  logic                     flag_stop;
  logic                     mosi;
  logic                     miso;
  logic                     sclk;
  logic                     cs;

  int checks;
  int errors;
  int timeouts;
  int start_pulses;
  int stop_pulses;

  // reference state of both FIFOs and the byte positions.
  logic [DW-1:0] send_ref[$];
  logic [DW-1:0] recv_ref[$];
  logic          overflow_ref;
  int            tx_pos;
  int            rx_cnt;
  logic [DW-1:0] rx_acc;

  pu_slave_spi u_pu_slave_spi (
    .clk         (clk),
    .rst         (rst),
    .signal_cycle(signal_cycle),
    .signal_wr   (signal_wr),
    .data_in     (data_in),
    .signal_oe   (signal_oe),
    .data_out    (data_out),
    .attr_out    (attr_out),
    .flag_start  (flag_start),
    .flag_stop   (flag_stop),
    .mosi        (mosi),
    .miso        (miso),
    .sclk        (sclk),
    .cs          (cs)
  );

  always #4 clk = ~clk;

  always @(negedge clk) begin
    if (!rst && flag_start) begin
      start_pulses++;
    end
    if (!rst && flag_stop) begin
      stop_pulses++;
    end
    if (!rst && !signal_oe) begin
      assert (data_out == '0 && attr_out == '0) else begin
        errors++;
        $display("error %0t data_out/attr_out expected 0/0 got %h/%h", $time, data_out,
                 attr_out);
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) flag_start |=> !flag_start)
    else begin
      errors++;
      $display("error %0t flag_start expected 0 got 1", $time);
    end

  assert property (@(posedge clk) disable iff (rst) flag_stop |=> !flag_stop)
    else begin
      errors++;
      $display("error %0t flag_stop expected 0 got 1", $time);
    end

  task automatic check_value(input string name, input logic [DW-1:0] expected,
                             input logic [DW-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("error %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // waits for the flag, then pads out one sclk half period.
  task automatic wait_flag(input bit want_start);
    int n;
    n = 0;
    while (n < HALF_CLK && !(want_start ? flag_start : flag_stop)) begin
      wait_cycles(1);
      n++;
    end
    if (!(want_start ? flag_start : flag_stop)) begin
      timeouts++;
      $display("%s did not pulse within %0d cycles of the cs edge",
               want_start ? "flag_start" : "flag_stop", HALF_CLK);
    end
    repeat (HALF_CLK - n) wait_cycles(1);
  endtask

  function automatic logic [BW-1:0] expected_miso_byte();
    logic [DW-1:0] w;
    if (send_ref.size() == 0) begin
      return spi_idle_byte;
    end
    w = send_ref[0];
    return BW'(w >> ((BPW - 1 - tx_pos) * BW));  // most significant byte first.
  endfunction

  task automatic update_model(input logic [BW-1:0] rx_b);
    if (send_ref.size() != 0) begin
      tx_pos++;
      if (tx_pos == BPW) begin
        void'(send_ref.pop_front());
        tx_pos = 0;
      end
    end
    rx_acc = {rx_acc[DW-BW-1:0], rx_b};
    rx_cnt++;
    if (rx_cnt == BPW) begin
      if (recv_ref.size() < NBUF) begin
        recv_ref.push_back(rx_acc);
      end else begin
        overflow_ref = 1'b1;  // full buffer drops the new word.
      end
      rx_cnt = 0;
    end
  endtask

  // mode 0 master that changes mosi with sclk low and takes miso at the rise.
  task automatic spi_transfer(input int nbytes);
    logic [BW-1:0] tx_b;
    logic [BW-1:0] rx_b;
    logic [BW-1:0] exp_b;
    int            s0;
    int            p0;
    s0 = start_pulses;
    p0 = stop_pulses;
    cs = 1'b0;
    wait_flag(1'b1);
    for (int i = 0; i < nbytes; i++) begin
      tx_b  = BW'($urandom);
      exp_b = expected_miso_byte();
      for (int b = BW - 1; b >= 0; b--) begin
        mosi = tx_b[b];
        wait_cycles(HALF_CLK);
        rx_b[b] = miso;
        sclk    = 1'b1;
        wait_cycles(HALF_CLK);
        sclk = 1'b0;
      end
      check_value("miso", DW'(exp_b), DW'(rx_b));
      update_model(tx_b);
    end
    wait_cycles(HALF_CLK);
    cs   = 1'b1;
    mosi = 1'b0;
    wait_flag(1'b0);
    tx_pos = 0;  // partial words start over.
    rx_cnt = 0;
    check_value("flag_start pulses", DW'(1), DW'(start_pulses - s0));
    check_value("flag_stop pulses", DW'(1), DW'(stop_pulses - p0));
  endtask

  task automatic write_word(input logic [DW-1:0] w);
    signal_wr = 1'b1;
    data_in   = w;
    wait_cycles(1);
    signal_wr = 1'b0;
    if (send_ref.size() < NBUF) begin
      send_ref.push_back(w);
    end
  endtask

  task automatic read_word();
    logic [DW-1:0]            exp_data;
    logic [pu_attr_width-1:0] exp_attr;
    exp_data = '0;
    exp_attr = '0;
    if (recv_ref.size() == 0) begin
      exp_attr[attr_invalid] = 1'b1;
    end else begin
      exp_data = recv_ref.pop_front();
    end
    exp_attr[attr_overflow] = overflow_ref;
    signal_oe = 1'b1;
    @(negedge clk);
    check_value("data_out", exp_data, data_out);
    check_value("attr_out", DW'(exp_attr), DW'(attr_out));
    wait_cycles(1);
    signal_oe = 1'b0;
  endtask

  task automatic cycle_clear();
    signal_cycle = 1'b1;
    wait_cycles(1);
    signal_cycle = 1'b0;
    wait_cycles(2);
    send_ref.delete();
    recv_ref.delete();
    overflow_ref = 1'b0;
    tx_pos       = 0;
    rx_cnt       = 0;
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    signal_cycle = 1'b0;
    signal_wr    = 1'b0;
    data_in      = '0;
    signal_oe    = 1'b0;
    mosi         = 1'b0;
    sclk         = 1'b0;
    cs           = 1'b1;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    start_pulses = 0;
    stop_pulses  = 0;
    overflow_ref = 1'b0;
    tx_pos       = 0;
    rx_cnt       = 0;
    rx_acc       = '0;
    void'($urandom(32'h253b_a8fd));
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_cycles(1);
    check_value("flag_start", '0, DW'(flag_start));
    check_value("flag_stop", '0, DW'(flag_stop));
    check_value("miso", DW'(spi_idle_byte[BW-1]), DW'(miso));
    read_word();
    // send and receive, then idle bytes once the send queue runs dry.
    for (int i = 0; i < 3; i++) write_word($urandom);
    spi_transfer(4 * BPW);
    for (int i = 0; i < 5; i++) read_word();
    // partial words at the end of a transfer.
    for (int i = 0; i < 4; i++) write_word($urandom);
    spi_transfer(BPW + 2);
    spi_transfer(2 * BPW);
    for (int i = 0; i < 4; i++) read_word();
    // one word more than the receive buffer holds.
    spi_transfer((NBUF + 1) * BPW);
    for (int i = 0; i < NBUF + 1; i++) read_word();
    for (int i = 0; i < NBUF + 1; i++) write_word($urandom);
    cycle_clear();
    read_word();
    spi_transfer(BPW);
    read_word();
    read_word();
    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #200000;
    timeouts++;
    $display("simulation did not finish within 200 us");
    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== pu_slave_spi.f ====
common/pu_spi_pkg.sv
common/spi_proto_pkg.sv
spi/spi_slave_driver.sv
spi/spi_buffer.sv
spi/spi_transfer_framer.sv
src/pu_slave_spi.sv
sim/tb_pu_slave_spi.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module tb_pu_slave_spi \
  -f pu_slave_spi.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or run error"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "sim passed" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
